// ==== lke_cfg.svh ====
`ifndef LKE_CFG_SVH
`define LKE_CFG_SVH

// ========================================
// datapath widths
// ========================================
`define LKE_CTRL_W      64
`define LKE_PHV_W       128
`define LKE_ACT_BANKS   3
`define LKE_ACT_W       (`LKE_ACT_BANKS * `LKE_CTRL_W)

// action table
`define LKE_ADDR_W      4
`define LKE_DEPTH       16

// vlan id field inside the phv
`define LKE_VLAN_W      12
`define LKE_VLAN_LSB    4

// ========================================
// control packet identification
// ========================================
`define LKE_STAGE_ID    5'd3
`define LKE_LOOKUP_ID   3'd2
`define LKE_CTRL_FLAG   16'hf2f1

// field positions in the second control beat
`define LKE_FLAG_LSB    0
`define LKE_MODID_LSB   16
`define LKE_RESV_LSB    24
`define LKE_INDEX_LSB   32

// action emitted when the key did not hit
`define LKE_ACT_MISS    192'h3f

`endif

// ==== lke_pkg.sv ====
`include "lke_cfg.svh"

package lke_pkg;

    // control bus payload
    typedef logic [`LKE_CTRL_W-1:0] ctrl_data_t;

    // packet header vector
    typedef logic [`LKE_PHV_W-1:0] phv_t;

    // full action entry and one bank slice of it
    typedef logic [`LKE_ACT_W-1:0]  act_entry_t;
    typedef logic [`LKE_CTRL_W-1:0] act_slice_t;

    typedef logic [`LKE_ADDR_W-1:0] tbl_addr_t;

    typedef logic [`LKE_VLAN_W-1:0] vlan_id_t;

    // one beat on the control bus
    typedef struct packed {
        ctrl_data_t data;
        logic       last;
        logic       valid;
    } ctrl_beat_t;

    // control path parser
    typedef enum logic [1:0] {
        cfg_idle,
        cfg_parse,
        cfg_seg,
        cfg_flush
    } cfg_state_e;

    // lookup data path
    typedef enum logic [1:0] {
        lkp_idle,
        lkp_wait,
        lkp_halt
    } lkp_state_e;

endpackage

// ==== lke_cfg_parser.sv ====
`timescale 1ns/1ps

`include "lke_cfg.svh"

module lke_cfg_parser (
    input  logic                clk,
    input  logic                rst_n,
    input  lke_pkg::ctrl_beat_t ctrl_in,
    output lke_pkg::ctrl_beat_t ctrl_out,
    output logic                wr_en,
    output lke_pkg::tbl_addr_t  wr_addr,
    output lke_pkg::act_entry_t wr_data
);

    import lke_pkg::*;

    cfg_state_e state;
    cfg_state_e state_next;
    logic [1:0] seg_cnt;
    logic [1:0] seg_next;

    // held first beat and one-cycle delayed input
    ctrl_data_t first_data;
    logic       first_last;
    logic       first_load;
    ctrl_data_t d1_data;
    logic       d1_last;
    logic       d1_valid;

    ctrl_beat_t emit;
    ctrl_data_t out_data;
    logic       out_last;
    logic       out_valid;

    logic       wr_en_next;
    logic       addr_load;
    logic       entry_load;
    act_entry_t entry_q;

    logic [15:0] hdr_flag;
    logic [7:0]  hdr_modid;
    logic [3:0]  hdr_resv;
    logic        is_cfg;

    // control data arrives little endian
    function automatic ctrl_data_t byte_swap(input ctrl_data_t d);
        ctrl_data_t s;
        for (int b = 0; b < `LKE_CTRL_W / 8; b++) begin
            s[b*8 +: 8] = d[`LKE_CTRL_W-8-b*8 +: 8];
        end
        return s;
    endfunction

    // ========================================
    // header decode, valid during cfg_parse
    // ========================================
    assign hdr_flag  = ctrl_in.data[`LKE_FLAG_LSB +: 16];
    assign hdr_modid = ctrl_in.data[`LKE_MODID_LSB +: 8];
    assign hdr_resv  = ctrl_in.data[`LKE_RESV_LSB +: 4];

    assign is_cfg = (hdr_flag == `LKE_CTRL_FLAG) &&
                    (hdr_modid[7:3] == `LKE_STAGE_ID) &&
                    (hdr_modid[2:0] == `LKE_LOOKUP_ID) &&
                    (hdr_resv != 4'd0);

    assign addr_load  = (state == cfg_parse) && ctrl_in.valid && is_cfg;
    assign entry_load = (state == cfg_seg) && ctrl_in.valid;

    always_comb begin
        state_next = state;
        seg_next   = seg_cnt;
        first_load = 1'b0;
        wr_en_next = 1'b0;
        emit       = '0;
        case (state)
            cfg_idle: begin
                if (ctrl_in.valid) begin
                    first_load = 1'b1;
                    state_next = cfg_parse;
                end
            end
            cfg_parse: begin
                if (ctrl_in.valid) begin
                    if (is_cfg) begin
                        seg_next   = 2'd0;
                        state_next = cfg_seg;
                    end else begin
                        emit       = '{data: first_data, last: first_last, valid: 1'b1};
                        state_next = cfg_flush;
                    end
                end
            end
            cfg_seg: begin
                if (ctrl_in.valid) begin
                    if (seg_cnt == 2'd2) begin
                        wr_en_next = 1'b1;
                        state_next = cfg_idle;
                    end else begin
                        seg_next = seg_cnt + 2'd1;
                    end
                end
            end
            cfg_flush: begin
                emit = '{data: d1_data, last: d1_last, valid: d1_valid};
                if (d1_valid && d1_last) begin
                    // next packet may follow right behind
                    if (ctrl_in.valid) begin
                        first_load = 1'b1;
                        state_next = cfg_parse;
                    end else begin
                        state_next = cfg_idle;
                    end
                end
            end
            default: state_next = cfg_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cfg_idle;
            seg_cnt   <= 2'd0;
            wr_en     <= 1'b0;
            d1_valid  <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            state     <= state_next;
            seg_cnt   <= seg_next;
            wr_en     <= wr_en_next;
            d1_valid  <= ctrl_in.valid;
            out_valid <= emit.valid;
            out_last  <= emit.last;
        end
    end

    always_ff @(posedge clk) begin
        d1_data  <= ctrl_in.data;
        d1_last  <= ctrl_in.last;
        out_data <= emit.data;
        if (first_load) begin
            first_data <= ctrl_in.data;
            first_last <= ctrl_in.last;
        end
        if (addr_load) begin
            wr_addr <= ctrl_in.data[`LKE_INDEX_LSB +: `LKE_ADDR_W];
        end
        // slice 0 sits at the top of the entry
        if (entry_load) begin
            entry_q[`LKE_ACT_W-1-seg_cnt*`LKE_CTRL_W -: `LKE_CTRL_W] <= byte_swap(ctrl_in.data);
        end
    end

    assign wr_data  = entry_q;
    assign ctrl_out = '{data: out_data, last: out_last, valid: out_valid};

    a_wr_single : assert property (@(posedge clk) disable iff (!rst_n) wr_en |=> !wr_en)
        else $error("table write strobe held for two cycles");

endmodule

// ==== lke_action_bank.sv ====
`timescale 1ns/1ps

`include "lke_cfg.svh"

module lke_action_bank (
    input  logic                clk,
    input  logic                wr_en,
    input  lke_pkg::tbl_addr_t  wr_addr,
    input  lke_pkg::act_slice_t wr_data,
    input  logic                rd_en,
    input  lke_pkg::tbl_addr_t  rd_addr,
    output lke_pkg::act_slice_t rd_data
);

    import lke_pkg::*;

    act_slice_t mem [`LKE_DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, old data on a same-address write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== lke_lookup_ctrl.sv ====
`timescale 1ns/1ps

`include "lke_cfg.svh"

module lke_lookup_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  lke_pkg::phv_t       phv_in,
    input  logic                phv_valid,
    input  lke_pkg::tbl_addr_t  match_addr,
    input  logic                if_match,
    output logic                ready_out,
    output logic                rd_en,
    output lke_pkg::tbl_addr_t  rd_addr,
    input  lke_pkg::act_entry_t rd_data,
    output lke_pkg::act_entry_t action,
    output logic                action_valid,
    output lke_pkg::phv_t       phv_out,
    input  logic                ready_in,
    output lke_pkg::vlan_id_t   act_vlan_out,
    output logic                act_vlan_out_valid,
    input  logic                act_vlan_ready
);

    import lke_pkg::*;

    lkp_state_e state;
    phv_t       phv_q;
    logic       hit_q;
    logic       accept;
    logic       out_fire;

    assign ready_out = (state == lkp_idle);
    assign accept    = phv_valid && ready_out;
    // downstream took the pending result
    assign out_fire  = (state != lkp_idle) && ready_in;

    // table read issued on the accepting edge
    assign rd_en   = accept;
    assign rd_addr = match_addr;

    assign action = hit_q ? rd_data : `LKE_ACT_MISS;

    // ========================================
    // lookup FSM
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state              <= lkp_idle;
            hit_q              <= 1'b0;
            action_valid       <= 1'b0;
            act_vlan_out_valid <= 1'b0;
        end else begin
            action_valid <= out_fire;
            if (accept) begin
                state              <= lkp_wait;
                hit_q              <= if_match;
                act_vlan_out_valid <= act_vlan_ready;
            end else if (out_fire) begin
                state              <= lkp_idle;
                act_vlan_out_valid <= 1'b0;
            end else if (state == lkp_wait) begin
                state <= lkp_halt;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (accept) begin
            phv_q        <= phv_in;
            act_vlan_out <= phv_in[`LKE_VLAN_LSB +: `LKE_VLAN_W];
        end
        if (out_fire) begin
            phv_out <= phv_q;
        end
    end

    a_single_action : assert property (
        @(posedge clk) disable iff (!rst_n) action_valid |=> !action_valid
    ) else $error("action_valid high on consecutive cycles");

    // no new lookup while halted, so the table word stays put
    a_no_accept_halt : assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == lkp_halt) |-> $stable(rd_data)
    ) else $error("table word changed during halt");

endmodule

// ==== lke_ram_top.sv ====
`timescale 1ns/1ps

`include "lke_cfg.svh"

module lke_ram_top (
    input  logic                clk,
    input  logic                rst_n,

    // from key extractor
    input  lke_pkg::phv_t       phv_in,
    input  logic                phv_valid,
    input  lke_pkg::tbl_addr_t  match_addr,
    input  logic                if_match,
    output logic                ready_out,

    // to action engine
    output lke_pkg::act_entry_t action,
    output logic                action_valid,
    output lke_pkg::phv_t       phv_out,
    input  logic                ready_in,
    output lke_pkg::vlan_id_t   act_vlan_out,
    output logic                act_vlan_out_valid,
    input  logic                act_vlan_ready,

    // control path
    input  lke_pkg::ctrl_beat_t ctrl_in,
    output lke_pkg::ctrl_beat_t ctrl_out
);

    import lke_pkg::*;

    logic            wr_en;
    tbl_addr_t       wr_addr;
    act_entry_t      wr_data;
    logic            rd_en;
    tbl_addr_t       rd_addr;
    wire act_entry_t rd_data;

    lke_cfg_parser u_parser (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl_in  (ctrl_in),
        .ctrl_out (ctrl_out),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data)
    );

    // ========================================
    // action table, one bank per slice
    // ========================================
    for (genvar i = 0; i < `LKE_ACT_BANKS; i++) begin : g_bank
        lke_action_bank u_bank (
            .clk     (clk),
            .wr_en   (wr_en),
            .wr_addr (wr_addr),
            .wr_data (wr_data[`LKE_ACT_W-1-i*`LKE_CTRL_W -: `LKE_CTRL_W]),
            .rd_en   (rd_en),
            .rd_addr (rd_addr),
            .rd_data (rd_data[`LKE_ACT_W-1-i*`LKE_CTRL_W -: `LKE_CTRL_W])
        );
    end

    lke_lookup_ctrl u_lookup (
        .clk                (clk),
        .rst_n              (rst_n),
        .phv_in             (phv_in),
        .phv_valid          (phv_valid),
        .match_addr         (match_addr),
        .if_match           (if_match),
        .ready_out          (ready_out),
        .rd_en              (rd_en),
        .rd_addr            (rd_addr),
        .rd_data            (rd_data),
        .action             (action),
        .action_valid       (action_valid),
        .phv_out            (phv_out),
        .ready_in           (ready_in),
        .act_vlan_out       (act_vlan_out),
        .act_vlan_out_valid (act_vlan_out_valid),
        .act_vlan_ready     (act_vlan_ready)
    );

endmodule

// ==== tb_lke_ram.sv ====
`timescale 1ns/1ps

`include "lke_cfg.svh"

module tb_lke_ram;

    import lke_pkg::*;

    logic       clk;
    logic       rst_n;
    phv_t       phv_in;
    logic       phv_valid;
    tbl_addr_t  match_addr;
    logic       if_match;
    logic       ready_out;
    act_entry_t action;
    logic       action_valid;
    phv_t       phv_out;
    logic       ready_in;
    vlan_id_t   act_vlan_out;
    logic       act_vlan_out_valid;
    logic       act_vlan_ready;
    ctrl_beat_t ctrl_in;
    ctrl_beat_t ctrl_out;

    // observed outputs, claimed by the trace lines in order
    ctrl_beat_t fwd_q[$];
    act_entry_t act_q[$];
    phv_t       phv_q[$];
    vlan_id_t   vlan_q[$];
    logic       vlan_valid_d;

    vlan_id_t   exp_vlan;
    logic       exp_vlan_on;
    string      test_name = "reset";
    int         cycle_cnt;
    int         cycle_limit;

    lke_ram_top u_dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .phv_in             (phv_in),
        .phv_valid          (phv_valid),
        .match_addr         (match_addr),
        .if_match           (if_match),
        .ready_out          (ready_out),
        .action             (action),
        .action_valid       (action_valid),
        .phv_out            (phv_out),
        .ready_in           (ready_in),
        .act_vlan_out       (act_vlan_out),
        .act_vlan_out_valid (act_vlan_out_valid),
        .act_vlan_ready     (act_vlan_ready),
        .ctrl_in            (ctrl_in),
        .ctrl_out           (ctrl_out)
    );

    always #4 clk = ~clk;

    task automatic check(input string what, input logic [255:0] exp, input logic [255:0] act);
        if (exp !== act) begin
            $display("Error: %s %s expected %h actual %h", test_name, what, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // ========================================
    // monitor and watchdog
    // ========================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (ctrl_out.valid) begin
                fwd_q.push_back(ctrl_out);
            end
            if (action_valid) begin
                act_q.push_back(action);
                phv_q.push_back(phv_out);
                // vlan strobe drops on the same edge
                check("act_vlan_out_valid at action", 0, act_vlan_out_valid);
            end
            if (act_vlan_out_valid && !vlan_valid_d) begin
                vlan_q.push_back(act_vlan_out);
            end
            vlan_valid_d = act_vlan_out_valid;
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("Timeout: no response from the DUT within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    // drop the control bus after the last beat of a packet
    task automatic release_ctrl();
        if (ctrl_in.valid) begin
            @(negedge clk);
            ctrl_in = '0;
        end
    endtask

    task automatic run_lookup(input phv_t phv, input tbl_addr_t addr, input logic hit,
                              input int stall, input logic vrdy);
        // idle gap also lets a pending table write land
        repeat (3) @(negedge clk);
        while (!ready_out) @(negedge clk);
        phv_in         = phv;
        match_addr     = addr;
        if_match       = hit;
        act_vlan_ready = vrdy;
        phv_valid      = 1'b1;
        ready_in       = (stall == 0);
        exp_vlan       = phv[`LKE_VLAN_LSB +: `LKE_VLAN_W];
        exp_vlan_on    = vrdy;
        @(negedge clk);
        phv_valid = 1'b0;
        repeat (stall) begin
            check("ready_out during halt", 0, ready_out);
            check("action_valid during halt", 0, action_valid);
            @(negedge clk);
        end
        ready_in = 1'b1;
    endtask

    task automatic expect_fwd(input ctrl_data_t data, input logic last);
        ctrl_beat_t got;
        release_ctrl();
        while (fwd_q.size() == 0) @(negedge clk);
        got = fwd_q.pop_front();
        check("ctrl_out data", data, got.data);
        check("ctrl_out last", last, got.last);
    endtask

    task automatic expect_action(input act_entry_t act, input phv_t phv);
        release_ctrl();
        while (act_q.size() == 0) @(negedge clk);
        check("action", act, act_q.pop_front());
        check("phv_out", phv, phv_q.pop_front());
        if (exp_vlan_on) begin
            check("act_vlan_out_valid rises", 1, vlan_q.size());
            check("act_vlan_out", exp_vlan, vlan_q.pop_front());
        end else begin
            check("act_vlan_out_valid rises", 0, vlan_q.size());
        end
    endtask

    // ========================================
    // trace driver
    // ========================================
    initial begin
        int         fd;
        int         n;
        int         n_lines;
        string      line;
        ctrl_data_t t_data;
        phv_t       t_phv;
        act_entry_t t_act;
        tbl_addr_t  t_addr;
        int         t_last;
        int         t_hit;
        int         t_stall;
        int         t_vrdy;

        clk            = 1'b0;
        rst_n          = 1'b0;
        phv_in         = '0;
        phv_valid      = 1'b0;
        match_addr     = '0;
        if_match       = 1'b0;
        ready_in       = 1'b1;
        act_vlan_ready = 1'b0;
        ctrl_in        = '0;
        vlan_valid_d   = 1'b0;
        exp_vlan       = '0;
        exp_vlan_on    = 1'b0;
        cycle_cnt      = 0;
        cycle_limit    = 0;

        fd = $fopen("lke_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file lke_trace.txt");
            $display("Testbench failed");
            $fatal(1);
        end
        n_lines = 0;
        while ($fgets(line, fd) > 0) begin
            n_lines++;
        end
        $fclose(fd);
        cycle_limit = 20 * n_lines + 100;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("lke_trace.txt", "r");
        while ($fgets(line, fd) > 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            case (line.getc(0))
                "T": begin
                    n = $sscanf(line, "T %s", test_name);
                end
                "C": begin
                    n = $sscanf(line, "C %h %h", t_data, t_last);
                    check("trace C fields", 2, n);
                    @(negedge clk);
                    ctrl_in = '{data: t_data, last: t_last[0], valid: 1'b1};
                end
                "P": begin
                    n = $sscanf(line, "P %h %h %h %d %h", t_phv, t_addr, t_hit, t_stall, t_vrdy);
                    check("trace P fields", 5, n);
                    release_ctrl();
                    run_lookup(t_phv, t_addr, t_hit[0], t_stall, t_vrdy[0]);
                end
                "F": begin
                    n = $sscanf(line, "F %h %h", t_data, t_last);
                    check("trace F fields", 2, n);
                    expect_fwd(t_data, t_last[0]);
                end
                "A": begin
                    n = $sscanf(line, "A %h %h", t_act, t_phv);
                    check("trace A fields", 2, n);
                    expect_action(t_act, t_phv);
                end
                default: begin
                    $display("Unknown line in the trace file: %s", line);
                    $display("Testbench failed");
                    $fatal(1);
                end
            endcase
        end
        $fclose(fd);

        release_ctrl();
        repeat (10) @(negedge clk);
        test_name = "drain";
        check("unclaimed ctrl_out beats", 0, fwd_q.size());
        check("unclaimed actions", 0, act_q.size());
        check("unclaimed vlan outputs", 0, vlan_q.size());
        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
lke_pkg.sv
lke_cfg_parser.sv
lke_action_bank.sv
lke_lookup_ctrl.sv
lke_ram_top.sv
tb_lke_ram.sv

// ==== lke_trace.txt ====
# C data last | P phv addr hit stall vlan_ready | F data last | A action phv | T name
# all values hex except the P stall count, decimal cycles with ready_in low
T fwd_bad_flag
C 1000000000000001 0
C 00000001011af2f0 0
C 1000000000000003 1
F 1000000000000001 0
F 00000001011af2f0 0
F 1000000000000003 1
T fwd_bad_stage
C 2000000000000001 0
C 000000010122f2f1 0
C 2000000000000003 0
C 2000000000000004 1
F 2000000000000001 0
F 000000010122f2f1 0
F 2000000000000003 0
F 2000000000000004 1
T fwd_zero_resv
C 3000000000000001 0
C 00000001001af2f1 1
F 3000000000000001 0
F 00000001001af2f1 1
T write_idx5_idx9
C 0000000000000000 0
C 00000005011af2f1 0
C 0102030405060708 0
C 1112131415161718 0
C 2122232425262728 1
C 0000000000000000 0
C 00000009011af2f1 0
C a1a2a3a4a5a6a7a8 0
C b1b2b3b4b5b6b7b8 0
C c1c2c3c4c5c6c7c8 1
T hit_idx5
P 0123456789abcdef0011223344556677 5 1 0 1
A 080706050403020118171615141312112827262524232221 0123456789abcdef0011223344556677
T hit_idx9_no_vlan
P fedcba98765432100f0e0d0c0b0a0908 9 1 0 0
A a8a7a6a5a4a3a2a1b8b7b6b5b4b3b2b1c8c7c6c5c4c3c2c1 fedcba98765432100f0e0d0c0b0a0908
T miss
P a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5 5 0 0 1
A 00000000000000000000000000000000000000000000003f a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5
P 00000000000000000000000000000ff0 9 0 2 0
A 00000000000000000000000000000000000000000000003f 00000000000000000000000000000ff0
T halt
P 13579bdf02468ace13579bdf02468ace 9 1 6 1
A a8a7a6a5a4a3a2a1b8b7b6b5b4b3b2b1c8c7c6c5c4c3c2c1 13579bdf02468ace13579bdf02468ace
T overwrite_idx5
C 0000000000000000 0
C 00000005011af2f1 0
C deadbeef00112233 0
C 0123456789abcdef 0
C fedcba9876543210 1
P 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a 5 1 3 1
A 33221100efbeaddeefcdab89674523011032547698badcfe 5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a5a
P 0000000100000002000000030000abcd 9 1 0 1
A a8a7a6a5a4a3a2a1b8b7b6b5b4b3b2b1c8c7c6c5c4c3c2c1 0000000100000002000000030000abcd
